// File: bench/rtg_tb.sv
// Self-checking testbench for rtg_top; drives the CPU bus, models the framebuffer and checks pixels
`timescale 1ns/1ps
`include "rtg_settings.svh"

module rtg_tb;

	// Largest random frame is 9 x 4 pixels
	localparam int FRAME_CYCLES = 4 * (9 + `RTG_LINE_GAP) + 40;
	localparam int TEST_CYCLES  = 80 + 4 * 256 + 8 * FRAME_CYCLES;
	localparam int WATCHDOG_CYCLES = 3 * TEST_CYCLES;

	logic        clk;
	logic        reset;
	logic        aen;
	logic        rd;
	logic        wr;
	logic [11:0] rs;
	logic [15:0] data_in;
	logic [15:0] data_out;
	logic        fb_rd;
	logic [31:0] fb_addr;
	logic [31:0] fb_data;
	logic        busy;
	rtg_pkg::rtg_pix_t pix;

	logic [31:0] lfsr;
	logic [31:0] fb_mem [0:4095];
	logic [23:0] pal_model [0:255];
	// Expected pixels as {sol, sof, rgb}
	logic [25:0] exp_q [$];
	// Expected framebuffer byte addresses in read order
	logic [31:0] addr_q [$];
	int          errors;
	int          checks;

	rtg_top dut_i (
		.clk      (clk),
		.reset    (reset),
		.aen      (aen),
		.rd       (rd),
		.wr       (wr),
		.rs       (rs),
		.data_in  (data_in),
		.data_out (data_out),
		.fb_rd    (fb_rd),
		.fb_addr  (fb_addr),
		.fb_data  (fb_data),
		.pix      (pix),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// One Galois LFSR step per random bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// --------------------
	// Reference model
	function automatic logic [31:0] bytes_per_pixel(input logic [5:0] fmt);
		case (fmt)
		6'd1:    return 32'd2;
		6'd2:    return 32'd4;
		default: return 32'd1;
		endcase
	endfunction

	function automatic logic [23:0] expect_rgb(input logic [5:0] fmt, input logic [31:0] addr);
		logic [31:0] w;
		logic [7:0]  pix_byte;
		logic [15:0] h;
		logic [4:0]  red5;
		logic [5:0]  grn6;
		logic [4:0]  blu5;
		w = fb_mem[addr[13:2]];
		pix_byte = 8'(w >> {addr[1:0], 3'b000});
		h = addr[1] ? w[31:16] : w[15:0];
		red5 = h[15:11];
		grn6 = h[10:5];
		blu5 = h[4:0];
		case (fmt)
		6'd0:    return pal_model[pix_byte];
		6'd1:    return {red5, red5[4:2], grn6, grn6[5:4], blu5, blu5[4:2]};
		6'd2:    return w[23:0];
		default: return 24'h000000;
		endcase
	endfunction

	// Expected pixel list and read addresses of one frame, row by row
	task automatic plan_frame(input rtg_pkg::rtg_mode_t f);
		logic [31:0] addr;
		logic [31:0] bpp;
		bpp = bytes_per_pixel(f.format);
		for (int y = 0; y < int'(f.vsize); y++) begin
			for (int x = 0; x < int'(f.hsize); x++) begin
				addr = f.base + 32'(y) * 32'(f.stride) + 32'(x) * bpp;
				addr_q.push_back(addr);
				exp_q.push_back({x == 0, (x == 0) && (y == 0), expect_rgb(f.format, addr)});
			end
		end
	endtask

	function automatic rtg_pkg::rtg_mode_t random_frame(input logic [5:0] fmt);
		rtg_pkg::rtg_mode_t f;
		f.ena    = 1'b1;
		f.base   = rand_bits(32);
		f.format = fmt;
		f.hsize  = 12'(rand_bits(3)) + 12'd2;
		f.vsize  = 12'(rand_bits(2)) + 12'd1;
		f.stride = 14'(rand_bits(14));
		return f;
	endfunction

	// --------------------
	// Bus access
	function automatic logic [11:0] reg_rs(input logic [2:0] sel);
		return {8'h00, sel, 1'b0};
	endfunction

	function automatic logic [11:0] pal_rs(input logic [7:0] idx, input logic half);
		return {1'b0, 1'b1, idx, half, 1'b0};
	endfunction

	task automatic bus_write(input logic [11:0] addr, input logic [15:0] data);
		@(negedge clk);
		aen = 1'b1;
		wr = 1'b1;
		rd = 1'b0;
		rs = addr;
		data_in = data;
	endtask

	task automatic bus_idle();
		@(negedge clk);
		aen = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [23:0] got,
			input logic [23:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Readback is combinational and sampled mid-cycle
	task automatic check_read(input logic [11:0] addr, input logic [15:0] exp, input string name);
		@(negedge clk);
		aen = 1'b1;
		rd = 1'b1;
		wr = 1'b0;
		rs = addr;
		#2;
		check_value({"data_out ", name}, {8'h00, data_out}, {8'h00, exp});
	endtask

	task automatic load_mode(input rtg_pkg::rtg_mode_t f);
		bus_write(reg_rs(`RTG_REG_ADDR_HI), f.base[31:16]);
		bus_write(reg_rs(`RTG_REG_ADDR_LO), f.base[15:0]);
		bus_write(reg_rs(`RTG_REG_FORMAT), {10'h000, f.format});
		bus_write(reg_rs(`RTG_REG_HSIZE), {4'h0, f.hsize});
		bus_write(reg_rs(`RTG_REG_VSIZE), {4'h0, f.vsize});
		bus_write(reg_rs(`RTG_REG_STRIDE), {2'b00, f.stride});
		bus_idle();
	endtask

	task automatic wait_busy();
		do @(negedge clk); while (!busy);
	endtask

	task automatic wait_sof();
		do @(negedge clk); while (!(pix.valid && pix.sof));
	endtask

	// Wait for the frame to end and then a quiet stretch where any pixel is an error
	task automatic drain();
		do @(negedge clk); while (busy);
		repeat (12) @(negedge clk);
		checks++;
		assert (exp_q.size() == 0 && addr_q.size() == 0) else begin
			errors++;
			$display("Frame ended at %0t with %0d pixels and %0d reads never seen",
				$time, exp_q.size(), addr_q.size());
			exp_q.delete();
			addr_q.delete();
		end
	endtask

	// One frame with enable cleared as soon as it starts
	task automatic run_frame(input logic [5:0] fmt);
		rtg_pkg::rtg_mode_t f;
		f = random_frame(fmt);
		load_mode(f);
		plan_frame(f);
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0001);
		bus_idle();
		wait_busy();
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0000);
		bus_idle();
		drain();
	endtask

	// --------------------
	// Framebuffer model returns the word the cycle after the strobe
	initial begin
		logic        rd_pend;
		logic [31:0] rd_addr;
		rd_pend = 1'b0;
		rd_addr = 32'h0;
		fb_data = 32'h0;
		forever begin
			@(negedge clk);
			fb_data = rd_pend ? fb_mem[rd_addr[13:2]] : 32'h0;
			rd_pend = fb_rd && !reset;
			rd_addr = fb_addr;
		end
	end

	// Pixel and read address monitor
	initial begin
		logic [1:0]  rd_hist;
		logic [25:0] exp;
		logic [31:0] exp_addr;
		rd_hist = 2'b00;
		forever begin
			@(negedge clk);
			if (reset) begin
				rd_hist = 2'b00;
			end else begin
				// Pixel two cycles after each read strobe
				check_value("pix.valid", {23'h0, pix.valid}, {23'h0, rd_hist[1]});
				if (pix.valid) begin
					checks++;
					assert (exp_q.size() != 0) else begin
						errors++;
						$display("Pixel output at %0t when no pixel was expected", $time);
					end
					if (exp_q.size() != 0) begin
						exp = exp_q.pop_front();
						check_value("pix.rgb", pix.rgb, exp[23:0]);
						check_value("pix.sol", {23'h0, pix.sol}, {23'h0, exp[25]});
						check_value("pix.sof", {23'h0, pix.sof}, {23'h0, exp[24]});
					end
				end
				if (fb_rd) begin
					checks++;
					assert (addr_q.size() != 0) else begin
						errors++;
						$display("Framebuffer read at %0t when no read was expected", $time);
					end
					if (addr_q.size() != 0) begin
						exp_addr = addr_q.pop_front();
						checks++;
						assert (fb_addr === exp_addr) else begin
							errors++;
							$display("Mismatch at %0t: fb_addr got %h expected %h",
								$time, fb_addr, exp_addr);
						end
					end
				end
				rd_hist = {rd_hist[0], fb_rd};
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired at %0t, the run did not finish", $time);
		$display("Checks: %0d  Errors: %0d", checks, errors + 1);
		$display("=== FAIL ===");
		$finish;
	end

	// --------------------
	// Test sequence
	initial begin
		rtg_pkg::rtg_mode_t mode_a;
		rtg_pkg::rtg_mode_t mode_b;
		logic [15:0] v;
		logic [7:0]  red;
		logic [15:0] gb;
		errors = 0;
		checks = 0;
		lfsr = 32'h1c11;
		reset = 1'b1;
		aen = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		rs = 12'h000;
		data_in = 16'h0000;
		for (int i = 0; i < 4096; i++) begin
			fb_mem[i] = rand_bits(32);
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Idle after reset and register readback
		repeat (4) begin
			@(negedge clk);
			checks++;
			assert (!busy && !fb_rd) else begin
				errors++;
				$display("Scan active at %0t right after reset", $time);
			end
		end
		check_read(reg_rs(`RTG_REG_ENABLE), 16'h0000, "enable");
		v = 16'(rand_bits(16));
		bus_write(reg_rs(`RTG_REG_ADDR_HI), v);
		check_read(reg_rs(`RTG_REG_ADDR_HI), v, "addr_hi");
		v = 16'(rand_bits(16));
		bus_write(reg_rs(`RTG_REG_ADDR_LO), v);
		check_read(reg_rs(`RTG_REG_ADDR_LO), v, "addr_lo");
		v = 16'(rand_bits(16));
		bus_write(reg_rs(`RTG_REG_FORMAT), v);
		check_read(reg_rs(`RTG_REG_FORMAT), {10'h000, v[5:0]}, "format");
		v = 16'(rand_bits(16));
		bus_write(reg_rs(`RTG_REG_HSIZE), v);
		check_read(reg_rs(`RTG_REG_HSIZE), {4'h0, v[11:0]}, "hsize");
		v = 16'(rand_bits(16));
		bus_write(reg_rs(`RTG_REG_VSIZE), v);
		check_read(reg_rs(`RTG_REG_VSIZE), {4'h0, v[11:0]}, "vsize");
		v = 16'(rand_bits(16));
		bus_write(reg_rs(`RTG_REG_STRIDE), v);
		check_read(reg_rs(`RTG_REG_STRIDE), {2'b00, v[13:0]}, "stride");
		check_read(reg_rs(`RTG_REG_ID), 16'h5001, "id");
		bus_idle();

		// Even palette entries end on the green/blue word and odd ones on the red byte
		for (int i = 0; i < 256; i++) begin
			red = 8'(rand_bits(8));
			gb = 16'(rand_bits(16));
			if (i % 2 == 0) begin
				bus_write(pal_rs(8'(i), 1'b0), {8'h00, red});
				bus_write(pal_rs(8'(i), 1'b1), gb);
			end else begin
				bus_write(pal_rs(8'(i), 1'b1), gb);
				bus_write(pal_rs(8'(i), 1'b0), {8'h00, red});
			end
			pal_model[i] = {red, gb};
		end
		for (int i = 0; i < 256; i++) begin
			check_read(pal_rs(8'(i), 1'b0), {8'h00, pal_model[i][23:16]}, "palette red");
			check_read(pal_rs(8'(i), 1'b1), pal_model[i][15:0], "palette green/blue");
		end
		bus_idle();

		// Single frames in each format
		run_frame(6'd0);
		run_frame(6'd0);
		run_frame(6'd1);
		run_frame(6'd1);
		run_frame(6'd2);
		run_frame(6'(rand_bits(6)) | 6'h08);

		// New mode written during frame A only applies to frame B
		mode_a = random_frame(6'd0);
		mode_a.vsize = 12'd4;
		mode_b = random_frame(6'd1);
		mode_b.vsize = 12'd4;
		load_mode(mode_a);
		plan_frame(mode_a);
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0001);
		bus_idle();
		wait_sof();
		plan_frame(mode_b);
		load_mode(mode_b);
		wait_sof();
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0000);
		bus_idle();
		drain();

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: rtg.f
+incdir+rtl
rtl/rtg_pkg.sv
rtl/rtg_regs.sv
rtl/rtg_clut.sv
rtl/rtg_scan_ctrl.sv
rtl/rtg_addr_gen.sv
rtl/rtg_pixel.sv
rtl/rtg_top.sv
bench/rtg_tb.sv

// File: rtl/rtg_addr_gen.sv
// Address generator of the RTG core, turning scan steps into framebuffer byte addresses and reads
`timescale 1ns/1ps

module rtg_addr_gen (
	input  logic                clk,
	input  logic                reset,
	input  rtg_pkg::rtg_mode_t  mode,
	input  rtg_pkg::rtg_scan_t  scan,
	output logic                fb_rd,
	output logic [31:0]         fb_addr,
	output rtg_pkg::rtg_fetch_t fetch
);

	logic [31:0] line_addr;
	logic [31:0] pix_addr;
	logic [31:0] cur_line;
	logic [31:0] cur_addr;
	logic [13:0] stride_q;
	logic [5:0]  fmt_q;
	logic [2:0]  bpp;
	logic        frame_first;

	assign frame_first = scan.first_x && scan.first_y;

	// Bytes per pixel for the frame format
	// Unknown formats step like CLUT8
	always_comb begin
		case (fmt_q)
		rtg_pkg::FMT_RGB565: bpp = 3'd2;
		rtg_pkg::FMT_RGB888: bpp = 3'd4;
		default:             bpp = 3'd1;
		endcase
	end

	// --------------------
	// Line start and pixel address of the current step
	always_comb begin
		cur_line = line_addr;
		cur_addr = pix_addr + 32'(bpp);
		if (frame_first) begin
			cur_line = mode.base;
			cur_addr = mode.base;
		end else if (scan.first_x) begin
			cur_line = line_addr + 32'(stride_q);
			cur_addr = cur_line;
		end
	end

	// Address registers advance only on a step
	always_ff @(posedge clk) begin
		if (scan.step) begin
			line_addr <= cur_line;
			pix_addr  <= cur_addr;
			fb_addr   <= cur_addr;
			if (frame_first) begin
				stride_q <= mode.stride;
				fmt_q    <= mode.format;
			end
		end
	end

	// --------------------
	// Read strobe and lane marks, one cycle after the step
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch <= '0;
		end else begin
			fetch.valid <= scan.step;
			fetch.lane  <= cur_addr[1:0];
			fetch.sol   <= scan.step && scan.first_x;
			fetch.sof   <= scan.step && frame_first;
		end
	end

	assign fb_rd = fetch.valid;

endmodule

// File: rtl/rtg_clut.sv
// Colour lookup table of the RTG core, with a CPU port and a registered pixel read port
`timescale 1ns/1ps
`include "rtg_settings.svh"

module rtg_clut (
	input  logic        clk,
	input  logic [7:0]  bus_addr,
	input  logic [23:0] bus_wdata,
	input  logic        bus_we,
	output logic [23:0] bus_rdata,
	input  logic [7:0]  pix_index,
	output logic [23:0] pix_rgb
);

	// One RGB888 entry per 8-bit index
	logic [23:0] mem [0:`RTG_CLUT_DEPTH-1];

	// --------------------
	// Bus port, write on the strobe edge
	always_ff @(posedge clk) begin
		if (bus_we) begin
			mem[bus_addr] <= bus_wdata;
		end
	end

	// Readback is asynchronous so the CPU sees it in the same cycle
	assign bus_rdata = mem[bus_addr];

	// --------------------
	// Pixel port
	// Index presented with the framebuffer word, entry out the next cycle
	always_ff @(posedge clk) begin
		pix_rgb <= mem[pix_index];
	end

endmodule

// File: rtl/rtg_pixel.sv
// Pixel stage of the RTG core, selecting the lane of each framebuffer word and converting to RGB
`timescale 1ns/1ps

module rtg_pixel (
	input  logic                clk,
	input  logic                reset,
	input  rtg_pkg::rtg_mode_t  mode,
	input  rtg_pkg::rtg_fetch_t fetch,
	input  logic [31:0]         fb_data,
	output logic [7:0]          clut_index,
	input  logic [23:0]         clut_rgb,
	output rtg_pkg::rtg_pix_t   pix
);

	rtg_pkg::rtg_fetch_t fetch_d;
	rtg_pkg::rtg_pix_t   pix_q;
	logic [5:0]  fmt_q;
	logic [7:0]  byte_sel;
	logic [15:0] half_sel;
	logic [23:0] rgb_direct;
	logic        is_clut;
	logic        clut_q;

	// Format follows the first read of each frame
	always_ff @(posedge clk) begin
		if (fetch.valid && fetch.sof) begin
			fmt_q <= mode.format;
		end
	end

	// Marks wait one cycle for the memory word
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_d <= '0;
		end else begin
			fetch_d <= fetch;
		end
	end

	// --------------------
	// Lane select, little-endian
	always_comb begin
		case (fetch_d.lane)
		2'd0:    byte_sel = fb_data[7:0];
		2'd1:    byte_sel = fb_data[15:8];
		2'd2:    byte_sel = fb_data[23:16];
		default: byte_sel = fb_data[31:24];
		endcase
	end

	assign half_sel   = fetch_d.lane[1] ? fb_data[31:16] : fb_data[15:0];
	assign clut_index = byte_sel;

	// --------------------
	// Conversion of the direct formats
	always_comb begin
		is_clut    = 1'b0;
		rgb_direct = 24'h000000;
		case (fmt_q)
		rtg_pkg::FMT_CLUT8: is_clut = 1'b1;
		rtg_pkg::FMT_RGB565: begin
			// Top bits repeated into the low end
			rgb_direct = {half_sel[15:11], half_sel[15:13],
				half_sel[10:5], half_sel[10:9],
				half_sel[4:0], half_sel[4:2]};
		end
		rtg_pkg::FMT_RGB888: rgb_direct = fb_data[23:0];
		default: rgb_direct = 24'h000000;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_q  <= '0;
			clut_q <= 1'b0;
		end else begin
			pix_q.valid <= fetch_d.valid;
			pix_q.sol   <= fetch_d.sol;
			pix_q.sof   <= fetch_d.sof;
			pix_q.rgb   <= rgb_direct;
			clut_q      <= is_clut;
		end
	end

	// --------------------
	// CLUT entry arrives in the same cycle as the registered marks
	assign pix = '{
		valid: pix_q.valid,
		sol:   pix_q.sol,
		sof:   pix_q.sof,
		rgb:   clut_q ? clut_rgb : pix_q.rgb
	};

endmodule

// File: rtl/rtg_pkg.sv
// Types shared by the RTG display core, referenced by scoped name from each module
package rtg_pkg;

	// Pixel format codes, other values give black pixels
	typedef enum logic [5:0] {
		FMT_CLUT8  = 6'd0,
		FMT_RGB565 = 6'd1,
		FMT_RGB888 = 6'd2
	} rtg_fmt_e;

	// Scan controller states
	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		LINE_GAP
	} rtg_scan_state_e;

	// --------------------
	// Mode as held by the register block
	typedef struct packed {
		logic        ena;
		logic [31:0] base;
		logic [5:0]  format;
		logic [11:0] hsize;
		logic [11:0] vsize;
		logic [13:0] stride;
	} rtg_mode_t;

	// One pixel step from the controller
	typedef struct packed {
		logic step;
		logic first_x;
		logic first_y;
		logic last;
	} rtg_scan_t;

	// Marks that ride along with an outstanding framebuffer read
	typedef struct packed {
		logic       valid;
		logic [1:0] lane;
		logic       sol;
		logic       sof;
	} rtg_fetch_t;

	// Output pixel stream
	typedef struct packed {
		logic        valid;
		logic        sol;
		logic        sof;
		logic [23:0] rgb;
	} rtg_pix_t;

endpackage

// File: rtl/rtg_regs.sv
// CPU-side register block of the RTG core, holding mode registers, ID word and palette staging
`timescale 1ns/1ps
`include "rtg_settings.svh"

module rtg_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               aen,
	input  logic               rd,
	input  logic               wr,
	input  logic [11:0]        rs,
	input  logic [15:0]        data_in,
	output logic [15:0]        data_out,
	output rtg_pkg::rtg_mode_t mode,
	output logic [7:0]         pal_addr,
	output logic [23:0]        pal_wdata,
	output logic               pal_we,
	input  logic [23:0]        pal_rdata
);

	logic        acc;
	logic        wr_en;
	logic        pal_win;
	logic [2:0]  sel;
	logic        ena_q;
	logic [31:0] base_q;
	logic [5:0]  fmt_q;
	logic [11:0] hsize_q;
	logic [11:0] vsize_q;
	logic [13:0] stride_q;
	// Staged red byte and green/blue word
	logic [23:0] rpal;

	// --------------------
	// Decode
	assign acc     = aen && (rd || wr);
	assign wr_en   = aen && wr;
	assign pal_win = rs[`RTG_PAL_SEL_BIT];
	assign sel     = rs[3:1];

	// Enable is the only register that comes out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			ena_q <= 1'b0;
		end else if (wr_en && !pal_win && sel == `RTG_REG_ENABLE) begin
			ena_q <= data_in[0];
		end
	end

	// Remaining mode registers and the palette staging
	always_ff @(posedge clk) begin
		if (wr_en && !pal_win) begin
			case (sel)
			`RTG_REG_ADDR_HI: base_q[31:16] <= data_in;
			`RTG_REG_ADDR_LO: base_q[15:0] <= data_in;
			`RTG_REG_FORMAT:  fmt_q <= data_in[5:0];
			`RTG_REG_HSIZE:   hsize_q <= data_in[11:0];
			`RTG_REG_VSIZE:   vsize_q <= data_in[11:0];
			`RTG_REG_STRIDE:  stride_q <= data_in[13:0];
			default: ;
			endcase
		end
		if (wr_en && pal_win) begin
			// Low half-word holds red, high half-word holds green/blue
			if (!rs[1]) begin
				rpal[23:16] <= data_in[7:0];
			end else begin
				rpal[15:0] <= data_in;
			end
		end
	end

	assign mode = '{
		ena:    ena_q,
		base:   base_q,
		format: fmt_q,
		hsize:  hsize_q,
		vsize:  vsize_q,
		stride: stride_q
	};

	// --------------------
	// Palette port, entry chosen by rs[9:2]
	assign pal_addr = rs[9:2];
	assign pal_we   = wr_en && pal_win;
	// Each write merges the new half with the staged other half
	assign pal_wdata = rs[1] ? {rpal[23:16], data_in} : {data_in[7:0], rpal[15:0]};

	// --------------------
	// Readback, narrow registers zero-extended
	always_comb begin
		data_out = 16'h0000;
		if (acc && !pal_win) begin
			case (sel)
			`RTG_REG_ADDR_HI: data_out = base_q[31:16];
			`RTG_REG_ADDR_LO: data_out = base_q[15:0];
			`RTG_REG_FORMAT:  data_out = {10'h000, fmt_q};
			`RTG_REG_ENABLE:  data_out = {15'h0000, ena_q};
			`RTG_REG_HSIZE:   data_out = {4'h0, hsize_q};
			`RTG_REG_VSIZE:   data_out = {4'h0, vsize_q};
			`RTG_REG_STRIDE:  data_out = {2'b00, stride_q};
			`RTG_REG_ID:      data_out = `RTG_ID_WORD;
			default:          data_out = 16'h0000;
			endcase
		end else if (acc && pal_win) begin
			// Red in the low byte, or the green/blue word
			data_out = rs[1] ? pal_rdata[15:0] : {8'h00, pal_rdata[23:16]};
		end
	end

endmodule

// File: rtl/rtg_scan_ctrl.sv
// Scan FSM of the RTG core, stepping x/y over the frame and marking line and frame starts
`timescale 1ns/1ps
`include "rtg_settings.svh"

module rtg_scan_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  rtg_pkg::rtg_mode_t mode,
	output rtg_pkg::rtg_scan_t scan,
	output logic               busy
);

	rtg_pkg::rtg_scan_state_e state;
	logic [11:0] x;
	logic [11:0] y;
	logic [11:0] hsize_q;
	logic [11:0] vsize_q;
	logic [7:0]  gap_cnt;
	logic        start_ok;
	logic        line_end;
	logic        frame_end;
	logic        gap_done;
	logic        frame_start;

	// Zero sizes would never finish a line, so they keep the scan idle
	assign start_ok  = mode.ena && (mode.hsize != 12'd0) && (mode.vsize != 12'd0);
	assign line_end  = (x == hsize_q - 12'd1);
	assign frame_end = (y == vsize_q - 12'd1);
	assign gap_done  = (state == rtg_pkg::LINE_GAP) && (gap_cnt == 8'd0);
	// New frame from idle, or back to back after the last line gap
	assign frame_start = start_ok && ((state == rtg_pkg::IDLE) || (gap_done && frame_end));

	// --------------------
	// State and counters
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= rtg_pkg::IDLE;
			x       <= 12'd0;
			y       <= 12'd0;
			gap_cnt <= 8'd0;
		end else begin
			case (state)
			rtg_pkg::IDLE: begin
				if (frame_start) begin
					state <= rtg_pkg::ACTIVE;
					x     <= 12'd0;
					y     <= 12'd0;
				end
			end
			rtg_pkg::ACTIVE: begin
				if (line_end) begin
					x       <= 12'd0;
					gap_cnt <= 8'(`RTG_LINE_GAP - 1);
					state   <= rtg_pkg::LINE_GAP;
				end else begin
					x <= x + 12'd1;
				end
			end
			rtg_pkg::LINE_GAP: begin
				if (!gap_done) begin
					gap_cnt <= gap_cnt - 8'd1;
				end else if (!frame_end) begin
					y     <= y + 12'd1;
					state <= rtg_pkg::ACTIVE;
				end else if (frame_start) begin
					y     <= 12'd0;
					state <= rtg_pkg::ACTIVE;
				end else begin
					state <= rtg_pkg::IDLE;
				end
			end
			default: state <= rtg_pkg::IDLE;
			endcase
		end
	end

	// Frame size sampled once per frame
	always_ff @(posedge clk) begin
		if (frame_start) begin
			hsize_q <= mode.hsize;
			vsize_q <= mode.vsize;
		end
	end

	// --------------------
	// One step per active cycle
	assign scan = '{
		step:    (state == rtg_pkg::ACTIVE),
		first_x: (x == 12'd0),
		first_y: (y == 12'd0),
		last:    line_end && frame_end
	};

	assign busy = (state != rtg_pkg::IDLE);

endmodule

// File: rtl/rtg_settings.svh
// Register map, ID word and pipeline constants of the RTG display core, included by RTL and bench
`ifndef RTG_SETTINGS_SVH
`define RTG_SETTINGS_SVH

// --------------------
// Register word index, taken from rs[3:1]
`define RTG_REG_ADDR_HI 3'd0
`define RTG_REG_ADDR_LO 3'd1
`define RTG_REG_FORMAT  3'd2
`define RTG_REG_ENABLE  3'd3
`define RTG_REG_HSIZE   3'd4
`define RTG_REG_VSIZE   3'd5
`define RTG_REG_STRIDE  3'd6
`define RTG_REG_ID      3'd7

// rs bit that switches from the register window to the palette window
`define RTG_PAL_SEL_BIT 10

// Fixed ID 50, version 01
`define RTG_ID_WORD 16'h5001

// --------------------
// Palette size and scan/pipeline timing
`define RTG_CLUT_DEPTH 256
`define RTG_LINE_GAP   4
`define RTG_PIPE_LAT   3

`endif

// File: rtl/rtg_top.sv
// Top level of the RTG display core, tying the register block, scan FSM and pixel datapath
`timescale 1ns/1ps

module rtg_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              aen,
	input  logic              rd,
	input  logic              wr,
	input  logic [11:0]       rs,
	input  logic [15:0]       data_in,
	output logic [15:0]       data_out,
	output logic              fb_rd,
	output logic [31:0]       fb_addr,
	input  logic [31:0]       fb_data,
	output rtg_pkg::rtg_pix_t pix,
	output logic              busy
);

	rtg_pkg::rtg_mode_t  mode;
	rtg_pkg::rtg_scan_t  scan;
	rtg_pkg::rtg_fetch_t fetch;
	logic [7:0]  pal_addr;
	logic [23:0] pal_wdata;
	logic        pal_we;
	logic [23:0] pal_rdata;
	logic [7:0]  clut_index;
	logic [23:0] clut_rgb;

	// --------------------
	// CPU side
	rtg_regs regs_i (
		.clk       (clk),
		.reset     (reset),
		.aen       (aen),
		.rd        (rd),
		.wr        (wr),
		.rs        (rs),
		.data_in   (data_in),
		.data_out  (data_out),
		.mode      (mode),
		.pal_addr  (pal_addr),
		.pal_wdata (pal_wdata),
		.pal_we    (pal_we),
		.pal_rdata (pal_rdata)
	);

	rtg_clut clut_i (
		.clk       (clk),
		.bus_addr  (pal_addr),
		.bus_wdata (pal_wdata),
		.bus_we    (pal_we),
		.bus_rdata (pal_rdata),
		.pix_index (clut_index),
		.pix_rgb   (clut_rgb)
	);

	// --------------------
	// Scan and pixel pipeline
	rtg_scan_ctrl scan_i (
		.clk   (clk),
		.reset (reset),
		.mode  (mode),
		.scan  (scan),
		.busy  (busy)
	);

	rtg_addr_gen addr_i (
		.clk     (clk),
		.reset   (reset),
		.mode    (mode),
		.scan    (scan),
		.fb_rd   (fb_rd),
		.fb_addr (fb_addr),
		.fetch   (fetch)
	);

	rtg_pixel pixel_i (
		.clk        (clk),
		.reset      (reset),
		.mode       (mode),
		.fetch      (fetch),
		.fb_data    (fb_data),
		.clut_index (clut_index),
		.clut_rgb   (clut_rgb),
		.pix        (pix)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the RTG testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module rtg_tb -f rtg.f -o rtg_sim
./obj_dir/rtg_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
